// ==== rtl/rv_isa_pkg.sv ====
// RV64 subset only. ADDI, ADD, SUB, AND, OR, XOR, LUI, JAL, BEQ and BNE are encoded and all else decodes as NOP.
package rv_isa_pkg;

  // architectural widths
  localparam int unsigned XLEN      = 64;
  localparam int unsigned ILEN      = 32;
  localparam int unsigned REG_IDX_W = 5;
  localparam int unsigned NUM_REGS  = 32;

  typedef logic [XLEN-1:0]      xlen_t;
  typedef logic [ILEN-1:0]      inst_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // major opcodes, inst[6:0]
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // funct3 for OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 for branches
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;

  // funct7 that turns ADD into SUB
  localparam logic [6:0] F7_SUB     = 7'b0100000;

  typedef enum logic [3:0] {
    NOP,
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    LUI,
    JAL,
    BEQ,
    BNE
  } alu_op_e;

  // decoded instruction, 85 bits
  typedef struct packed {
    alu_op_e  alu_op;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    logic     rd_wen;
    // second operand from imm, not rs2
    logic     use_imm;
    xlen_t    imm;
  } decoded_t;

endpackage

// ==== rtl/core_pkg.sv ====
// Core-level constants for a single-issue multi-cycle core whose PC starts at zero and steps by one 32-bit word.
package core_pkg;

  // fetch starts here after reset
  localparam rv_isa_pkg::xlen_t RESET_PC = 64'h0;

  // sequential pc step
  localparam rv_isa_pkg::xlen_t INST_BYTES = 64'd4;

  // sequencer states
  typedef enum logic [1:0] {
    // req up, waiting for ack
    FETCH_REQ,
    // req down, waiting for ack release
    FETCH_REL,
    EXECUTE,
    COMMIT
  } seq_state_e;

  // one retired instruction, 134 bits
  typedef struct packed {
    rv_isa_pkg::xlen_t    pc;
    rv_isa_pkg::reg_idx_t rd;
    logic                 rd_wen;
    rv_isa_pkg::xlen_t    wdata;
  } commit_t;

endpackage

// ==== rtl/fetch_sequencer.sv ====
// Fetches one instruction at a time over a four-phase req/ack bus and waits without limit on the memory.
`timescale 1ns/1ps

module fetch_sequencer (
  input  logic                  clk,
  input  logic                  i_rst_n,
  input  logic                  i_ibus_ack,
  input  rv_isa_pkg::inst_t     i_ibus_rdata,
  output logic                  o_ibus_req,
  output rv_isa_pkg::xlen_t     o_ibus_addr,
  input  rv_isa_pkg::xlen_t     i_next_pc,
  input  rv_isa_pkg::xlen_t     i_wdata,
  input  rv_isa_pkg::decoded_t  i_dec,
  output rv_isa_pkg::inst_t     o_inst,
  output rv_isa_pkg::xlen_t     o_pc,
  output logic                  o_rf_wen,
  output logic                  o_cmt_valid,
  output core_pkg::commit_t     o_cmt
);

  core_pkg::seq_state_e state_q;
  logic                 req_q;
  rv_isa_pkg::xlen_t    pc_q;
  rv_isa_pkg::inst_t    inst_q;
  logic                 fetch_done;

  // ack seen while our request is up
  assign fetch_done = (state_q == core_pkg::FETCH_REQ) && req_q && i_ibus_ack;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state_q <= core_pkg::FETCH_REQ;
      req_q   <= 1'b0;
      pc_q    <= core_pkg::RESET_PC;
    end else begin
      case (state_q)
        core_pkg::FETCH_REQ: begin
          if (!req_q) begin
            // only after reset, raise once the bus is idle
            if (!i_ibus_ack) begin
              req_q <= 1'b1;
            end
          end else if (i_ibus_ack) begin
            req_q   <= 1'b0;
            state_q <= core_pkg::FETCH_REL;
          end
        end
        core_pkg::FETCH_REL: begin
          if (!i_ibus_ack) begin
            state_q <= core_pkg::EXECUTE;
          end
        end
        core_pkg::EXECUTE: begin
          state_q <= core_pkg::COMMIT;
        end
        core_pkg::COMMIT: begin
          // ack already seen low, next fetch can start at once
          pc_q    <= i_next_pc;
          req_q   <= 1'b1;
          state_q <= core_pkg::FETCH_REQ;
        end
        default: begin
          state_q <= core_pkg::FETCH_REQ;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_done) begin
      inst_q <= i_ibus_rdata;
    end
  end

  assign o_ibus_req  = req_q;
  assign o_ibus_addr = pc_q;
  assign o_inst      = inst_q;
  assign o_pc        = pc_q;
  assign o_cmt_valid = (state_q == core_pkg::COMMIT);
  assign o_rf_wen    = o_cmt_valid && i_dec.rd_wen;

  always_comb begin
    o_cmt.pc     = pc_q;
    o_cmt.rd     = i_dec.rd;
    o_cmt.rd_wen = i_dec.rd_wen;
    o_cmt.wdata  = i_wdata;
  end

endmodule

// ==== rtl/inst_decoder.sv ====
// Purely combinational decode of the ten supported encodings, anything else becomes a NOP with no register write.
`timescale 1ns/1ps

module inst_decoder (
  input  rv_isa_pkg::inst_t     i_inst,
  output rv_isa_pkg::decoded_t  o_dec
);

  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  rv_isa_pkg::xlen_t imm_i;
  rv_isa_pkg::xlen_t imm_u;
  rv_isa_pkg::xlen_t imm_j;
  rv_isa_pkg::xlen_t imm_b;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  // sign-extended immediates
  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};

  always_comb begin
    o_dec         = '0;
    o_dec.alu_op  = rv_isa_pkg::NOP;
    o_dec.rs1     = i_inst[19:15];
    o_dec.rs2     = i_inst[24:20];
    o_dec.rd      = i_inst[11:7];

    case (opcode)
      rv_isa_pkg::OPC_OP_IMM: begin
        // ADDI only
        if (funct3 == rv_isa_pkg::F3_ADD_SUB) begin
          o_dec.alu_op  = rv_isa_pkg::ADD;
          o_dec.use_imm = 1'b1;
          o_dec.imm     = imm_i;
        end
      end
      rv_isa_pkg::OPC_OP: begin
        if (funct7 == 7'b0) begin
          case (funct3)
            rv_isa_pkg::F3_ADD_SUB: o_dec.alu_op = rv_isa_pkg::ADD;
            rv_isa_pkg::F3_XOR:     o_dec.alu_op = rv_isa_pkg::XOR;
            rv_isa_pkg::F3_OR:      o_dec.alu_op = rv_isa_pkg::OR;
            rv_isa_pkg::F3_AND:     o_dec.alu_op = rv_isa_pkg::AND;
            default:                o_dec.alu_op = rv_isa_pkg::NOP;
          endcase
        end else if (funct7 == rv_isa_pkg::F7_SUB && funct3 == rv_isa_pkg::F3_ADD_SUB) begin
          o_dec.alu_op = rv_isa_pkg::SUB;
        end
      end
      rv_isa_pkg::OPC_LUI: begin
        o_dec.alu_op = rv_isa_pkg::LUI;
        o_dec.imm    = imm_u;
      end
      rv_isa_pkg::OPC_JAL: begin
        o_dec.alu_op = rv_isa_pkg::JAL;
        o_dec.imm    = imm_j;
      end
      rv_isa_pkg::OPC_BRANCH: begin
        o_dec.imm = imm_b;
        if (funct3 == rv_isa_pkg::F3_BEQ) begin
          o_dec.alu_op = rv_isa_pkg::BEQ;
        end else if (funct3 == rv_isa_pkg::F3_BNE) begin
          o_dec.alu_op = rv_isa_pkg::BNE;
        end
      end
      default: begin
        o_dec.alu_op = rv_isa_pkg::NOP;
      end
    endcase

    // no write for branches, unknown encodings or x0
    o_dec.rd_wen = (o_dec.alu_op != rv_isa_pkg::NOP) &&
                   (o_dec.alu_op != rv_isa_pkg::BEQ) &&
                   (o_dec.alu_op != rv_isa_pkg::BNE) &&
                   (o_dec.rd != '0);
  end

endmodule

// ==== rtl/regfile.sv ====
// Integer register file with x0 hardwired to zero and asynchronous reads, so a write is visible only after its edge.
`timescale 1ns/1ps

module regfile (
  input  logic                 clk,
  input  logic                 i_rst_n,
  input  rv_isa_pkg::reg_idx_t i_rs1,
  input  rv_isa_pkg::reg_idx_t i_rs2,
  output rv_isa_pkg::xlen_t    o_rs1_data,
  output rv_isa_pkg::xlen_t    o_rs2_data,
  input  logic                 i_wen,
  input  rv_isa_pkg::reg_idx_t i_rd,
  input  rv_isa_pkg::xlen_t    i_wdata
);

  // x0 has no storage
  rv_isa_pkg::xlen_t regs [1:rv_isa_pkg::NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      for (int i = 1; i < rv_isa_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_rd != '0)) begin
      regs[i_rd] <= i_wdata;
    end
  end

  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// ==== rtl/alu_execute.sv ====
// Combinational execute for the supported subset and the result is only meaningful while the held instruction is stable.
`timescale 1ns/1ps

module alu_execute (
  input  rv_isa_pkg::decoded_t i_dec,
  input  rv_isa_pkg::xlen_t    i_pc,
  input  rv_isa_pkg::xlen_t    i_rs1_data,
  input  rv_isa_pkg::xlen_t    i_rs2_data,
  output rv_isa_pkg::xlen_t    o_wdata,
  output rv_isa_pkg::xlen_t    o_next_pc
);

  rv_isa_pkg::xlen_t op2;
  rv_isa_pkg::xlen_t pc_seq;
  rv_isa_pkg::xlen_t pc_target;
  logic              src_equal;
  logic              taken;

  assign op2       = i_dec.use_imm ? i_dec.imm : i_rs2_data;
  assign pc_seq    = i_pc + core_pkg::INST_BYTES;
  assign pc_target = i_pc + i_dec.imm;

  // branches always compare two registers
  assign src_equal = (i_rs1_data == i_rs2_data);

  always_comb begin
    case (i_dec.alu_op)
      rv_isa_pkg::ADD: o_wdata = i_rs1_data + op2;
      rv_isa_pkg::SUB: o_wdata = i_rs1_data - op2;
      rv_isa_pkg::AND: o_wdata = i_rs1_data & op2;
      rv_isa_pkg::OR:  o_wdata = i_rs1_data | op2;
      rv_isa_pkg::XOR: o_wdata = i_rs1_data ^ op2;
      rv_isa_pkg::LUI: o_wdata = i_dec.imm;
      // link address
      rv_isa_pkg::JAL: o_wdata = pc_seq;
      default:         o_wdata = '0;
    endcase
  end

  always_comb begin
    case (i_dec.alu_op)
      rv_isa_pkg::JAL: taken = 1'b1;
      rv_isa_pkg::BEQ: taken = src_equal;
      rv_isa_pkg::BNE: taken = !src_equal;
      default:         taken = 1'b0;
    endcase
  end

  assign o_next_pc = taken ? pc_target : pc_seq;

endmodule

// ==== rtl/mini_rv_core.sv ====
// Top of the multi-cycle RV64 subset core, with an instruction bus only and no data memory, CSRs or interrupts.
`timescale 1ns/1ps

module mini_rv_core (
  input  logic                 clk,
  input  logic                 i_rst_n,
  output logic                 o_ibus_req,
  output rv_isa_pkg::xlen_t    o_ibus_addr,
  input  logic                 i_ibus_ack,
  input  rv_isa_pkg::inst_t    i_ibus_rdata,
  output logic                 o_cmt_valid,
  output core_pkg::commit_t    o_cmt
);

  rv_isa_pkg::inst_t    inst;
  rv_isa_pkg::xlen_t    pc;
  rv_isa_pkg::decoded_t dec;
  rv_isa_pkg::xlen_t    rs1_data;
  rv_isa_pkg::xlen_t    rs2_data;
  rv_isa_pkg::xlen_t    wdata;
  rv_isa_pkg::xlen_t    next_pc;
  logic                 rf_wen;

  fetch_sequencer u_fetch_sequencer (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_ibus_ack   (i_ibus_ack),
    .i_ibus_rdata (i_ibus_rdata),
    .o_ibus_req   (o_ibus_req),
    .o_ibus_addr  (o_ibus_addr),
    .i_next_pc    (next_pc),
    .i_wdata      (wdata),
    .i_dec        (dec),
    .o_inst       (inst),
    .o_pc         (pc),
    .o_rf_wen     (rf_wen),
    .o_cmt_valid  (o_cmt_valid),
    .o_cmt        (o_cmt)
  );

  inst_decoder u_inst_decoder (
    .i_inst (inst),
    .o_dec  (dec)
  );

  // both source reads in parallel with execute
  regfile u_regfile (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_rs1      (dec.rs1),
    .i_rs2      (dec.rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_wen      (rf_wen),
    .i_rd       (dec.rd),
    .i_wdata    (wdata)
  );

  alu_execute u_alu_execute (
    .i_dec      (dec),
    .i_pc       (pc),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_wdata    (wdata),
    .o_next_pc  (next_pc)
  );

endmodule

// ==== tb/rv_ref_model.sv ====
// Architectural model of the RV64 subset, which steps one instruction at each clock edge with i_step high.
`timescale 1ns/1ps

module rv_ref_model (
  input  logic                 clk,
  input  logic                 i_rst_n,
  input  logic                 i_step,
  input  rv_isa_pkg::inst_t    i_inst,
  output rv_isa_pkg::xlen_t    o_pc,
  output logic                 o_rd_wen,
  output rv_isa_pkg::reg_idx_t o_rd,
  output rv_isa_pkg::xlen_t    o_wdata
);

  rv_isa_pkg::xlen_t regs [32];
  rv_isa_pkg::xlen_t pc;
  rv_isa_pkg::xlen_t next_pc;
  rv_isa_pkg::xlen_t a;
  rv_isa_pkg::xlen_t b;
  rv_isa_pkg::xlen_t imm_i;
  rv_isa_pkg::xlen_t imm_u;
  rv_isa_pkg::xlen_t imm_j;
  rv_isa_pkg::xlen_t imm_b;

  assign a     = regs[i_inst[19:15]];
  assign b     = regs[i_inst[24:20]];
  assign imm_i = 64'($signed(i_inst[31:20]));
  assign imm_u = 64'($signed({i_inst[31:12], 12'b0}));
  assign imm_j = 64'($signed({i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0}));
  assign imm_b = 64'($signed({i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0}));
  assign o_pc  = pc;

  always_comb begin
    o_rd     = i_inst[11:7];
    o_rd_wen = 1'b0;
    o_wdata  = '0;
    next_pc  = pc + 64'd4;
    case (i_inst[6:0])
      7'b0010011: begin
        o_rd_wen = (i_inst[14:12] == 3'b000);
        o_wdata  = a + imm_i;
      end
      7'b0110011: begin
        o_rd_wen = 1'b1;
        // funct7 and funct3 together
        case ({i_inst[31:25], i_inst[14:12]})
          10'b0000000_000: o_wdata = a + b;
          10'b0100000_000: o_wdata = a - b;
          10'b0000000_100: o_wdata = a ^ b;
          10'b0000000_110: o_wdata = a | b;
          10'b0000000_111: o_wdata = a & b;
          default:         o_rd_wen = 1'b0;
        endcase
      end
      7'b0110111: begin
        o_rd_wen = 1'b1;
        o_wdata  = imm_u;
      end
      7'b1101111: begin
        o_rd_wen = 1'b1;
        o_wdata  = pc + 64'd4;
        next_pc  = pc + imm_j;
      end
      7'b1100011: begin
        if ((i_inst[14:12] == 3'b000 && a == b) || (i_inst[14:12] == 3'b001 && a != b)) begin
          next_pc = pc + imm_b;
        end
      end
      default: ;
    endcase
    if (o_rd == 5'd0) begin
      o_rd_wen = 1'b0;
    end
  end

  always @(posedge clk) begin
    if (!i_rst_n) begin
      pc <= '0;
      foreach (regs[i]) regs[i] <= '0;
    end else if (i_step) begin
      if (o_rd_wen) begin
        regs[o_rd] <= o_wdata;
      end
      pc <= next_pc;
    end
  end

endmodule

// ==== tb/tb_mini_rv_core.sv ====
// Random-program testbench whose 64-word instruction memory repeats every 256 bytes of address.
`timescale 1ns/1ps

module tb_mini_rv_core;

  localparam int N_RANDOM       = 400;
  localparam int N_READOUT      = 32;
  localparam int TIMEOUT_CYCLES = (N_RANDOM + N_READOUT) * 20 + 100;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 ibus_req;
  rv_isa_pkg::xlen_t    ibus_addr;
  logic                 ibus_ack;
  rv_isa_pkg::inst_t    ibus_rdata;
  logic                 cmt_valid;
  core_pkg::commit_t    cmt;
  logic                 step;
  rv_isa_pkg::xlen_t    exp_pc;
  logic                 exp_wen;
  rv_isa_pkg::reg_idx_t exp_rd;
  rv_isa_pkg::xlen_t    exp_wdata;
  rv_isa_pkg::inst_t    model_inst;
  rv_isa_pkg::inst_t    imem [64];
  int                   seed;
  int                   err_cnt [1:5];
  int                   check_cnt;
  int                   n_commits;
  int                   cycles = 0;
  int                   delay;
  int                   total_err;
  bit                   armed;
  bit                   in_readout;
  bit                   first_req_seen;
  logic                 req_prev;
  rv_isa_pkg::xlen_t    addr_prev;

  always #20 clk = ~clk;

  mini_rv_core i_dut (
    .clk          (clk),
    .i_rst_n      (rst_n),
    .o_ibus_req   (ibus_req),
    .o_ibus_addr  (ibus_addr),
    .i_ibus_ack   (ibus_ack),
    .i_ibus_rdata (ibus_rdata),
    .o_cmt_valid  (cmt_valid),
    .o_cmt        (cmt)
  );

  rv_ref_model u_ref_model (
    .clk      (clk),
    .i_rst_n  (rst_n),
    .i_step   (step),
    .i_inst   (model_inst),
    .o_pc     (exp_pc),
    .o_rd_wen (exp_wen),
    .o_rd     (exp_rd),
    .o_wdata  (exp_wdata)
  );

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    return int'((r & 32'h7fff_ffff) % n);
  endfunction

  function automatic rv_isa_pkg::inst_t gen_inst();
    int                kind;
    int                off;
    logic [4:0]        rd;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic [11:0]       imm12;
    logic [20:0]       joff;
    logic [12:0]       boff;
    rv_isa_pkg::inst_t w;
    kind  = rand_below(16);
    rd    = 5'(rand_below(32));
    rs1   = 5'(rand_below(12));
    rs2   = 5'(rand_below(12));
    imm12 = 12'($random(seed));
    // jump distance of -4..-1 or 1..8 words
    off   = rand_below(12) - 4;
    off   = (off >= 0) ? off + 1 : off;
    joff  = 21'(off * 4);
    boff  = 13'(off * 4);
    case (kind)
      0: w = {25'($random(seed)), 7'b0001011};
      1, 2, 3: w = {imm12, rs1, 3'b000, rd, 7'b0010011};
      4: w = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
      5: w = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
      6: w = {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
      7: w = {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
      8: w = {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
      9, 10: w = {20'($random(seed)), rd, 7'b0110111};
      11: w = {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'b1101111};
      12, 13: w = {boff[12], boff[10:5], rs2, rs1, 3'b000, boff[4:1], boff[11], 7'b1100011};
      default: w = {boff[12], boff[10:5], rs2, rs1, 3'b001, boff[4:1], boff[11], 7'b1100011};
    endcase
    return w;
  endfunction

  // ADDI xk, xk, 0 everywhere so any 32 sequential commits read out every register
  task automatic load_readout_block();
    logic [4:0] r;
    for (int i = 0; i < 64; i++) begin
      r = 5'(i);
      imem[i] = {12'h000, r, 3'b000, r, 7'b0010011};
    end
  endtask

  task automatic report_test(input int id, input string name);
    $display("test %0d %s finished with %0d errors", id, name, err_cnt[id]);
  endtask

  task automatic check_commit();
    int t;
    t = 3;
    if (model_inst[6:0] == 7'b1101111 || model_inst[6:0] == 7'b1100011) begin
      t = 4;
    end
    if (in_readout) begin
      t = 5;
    end
    check_cnt += 2;
    if (cmt.pc !== exp_pc) begin
      err_cnt[in_readout ? 5 : 4]++;
      $display("ERROR %0t o_cmt.pc expected %h got %h", $time, exp_pc, cmt.pc);
    end
    if (cmt.rd_wen !== exp_wen) begin
      err_cnt[t]++;
      $display("ERROR %0t o_cmt.rd_wen expected %b got %b", $time, exp_wen, cmt.rd_wen);
    end
    if (exp_wen) begin
      check_cnt += 2;
      if (cmt.rd !== exp_rd) begin
        err_cnt[t]++;
        $display("ERROR %0t o_cmt.rd expected %0d got %0d", $time, exp_rd, cmt.rd);
      end
      if (cmt.wdata !== exp_wdata) begin
        err_cnt[t]++;
        $display("ERROR %0t o_cmt.wdata expected %h got %h", $time, exp_wdata, cmt.wdata);
      end
    end
  endtask

  // memory side of the four-phase handshake with 0 to 5 cycles per phase
  always @(negedge clk) begin
    if (!rst_n) begin
      ibus_ack <= 1'b0;
      armed = 1'b0;
    end else begin
      if (!armed && ((!ibus_ack && ibus_req) || (ibus_ack && !ibus_req))) begin
        delay = rand_below(6);
        armed = 1'b1;
      end
      if (armed && delay > 0) begin
        delay--;
      end else if (armed) begin
        armed = 1'b0;
        ibus_ack <= !ibus_ack;
        if (!ibus_ack) ibus_rdata <= imem[ibus_addr[7:2]];
      end
    end
  end

  // reset values and bus rules
  always @(negedge clk) begin
    if (!rst_n) begin
      if (ibus_req !== 1'b0) begin
        err_cnt[1]++;
        $display("ERROR %0t o_ibus_req expected 0 got %b", $time, ibus_req);
      end
      if (cmt_valid !== 1'b0) begin
        err_cnt[1]++;
        $display("ERROR %0t o_cmt_valid expected 0 got %b", $time, cmt_valid);
      end
    end else begin
      if (ibus_req && !first_req_seen) begin
        first_req_seen = 1'b1;
        if (ibus_addr !== core_pkg::RESET_PC) begin
          err_cnt[1]++;
          $display("ERROR %0t o_ibus_addr expected %h got %h", $time, core_pkg::RESET_PC, ibus_addr);
        end
      end
      if (ibus_req && !req_prev && ibus_ack) begin
        err_cnt[2]++;
        $display("at %0t the request rose while the memory still held ack high", $time);
      end
      if (ibus_req && req_prev && ibus_addr !== addr_prev) begin
        err_cnt[2]++;
        $display("at %0t the fetch address changed while the request was high", $time);
      end
    end
    req_prev  = ibus_req;
    addr_prev = ibus_addr;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run stopped by timeout after %0d cycles with %0d commits", cycles, n_commits);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    rst_n          = 1'b0;
    ibus_ack       = 1'b0;
    ibus_rdata     = '0;
    step           = 1'b0;
    seed           = 39;
    check_cnt      = 0;
    n_commits      = 0;
    in_readout     = 1'b0;
    first_req_seen = 1'b0;
    armed          = 1'b0;
    delay          = 0;
    req_prev       = 1'b0;
    addr_prev      = '0;
    foreach (err_cnt[i]) err_cnt[i] = 0;
    for (int i = 0; i < 64; i++) begin
      imem[i] = gen_inst();
    end
    repeat (10) @(negedge clk);
    rst_n <= 1'b1;
    while (n_commits < N_RANDOM + N_READOUT) begin
      @(negedge clk);
      // word address modulo 64
      model_inst = imem[exp_pc[7:2]];
      step <= cmt_valid;
      if (cmt_valid) begin
        if (n_commits == 0) report_test(1, "reset state");
        check_commit();
        n_commits++;
        if (n_commits == N_RANDOM) begin
          report_test(3, "arithmetic and LUI");
          report_test(4, "control flow");
          load_readout_block();
          in_readout = 1'b1;
        end
      end
    end
    report_test(5, "register state");
    report_test(2, "handshake rule");
    total_err = err_cnt[1] + err_cnt[2] + err_cnt[3] + err_cnt[4] + err_cnt[5];
    $display("commits %0d, checks %0d, errors %0d", n_commits, check_cnt, total_err);
    if (total_err == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== mini_rv_core.f ====
rtl/rv_isa_pkg.sv
rtl/core_pkg.sv
rtl/fetch_sequencer.sv
rtl/inst_decoder.sv
rtl/regfile.sv
rtl/alu_execute.sv
rtl/mini_rv_core.sv
tb/rv_ref_model.sv
tb/tb_mini_rv_core.sv

// ==== Bender.yml ====
package:
  name: mini_rv_core

sources:
  - rtl/rv_isa_pkg.sv
  - rtl/core_pkg.sv
  - rtl/fetch_sequencer.sv
  - rtl/inst_decoder.sv
  - rtl/regfile.sv
  - rtl/alu_execute.sv
  - rtl/mini_rv_core.sv
  - target: test
    files:
      - tb/rv_ref_model.sv
      - tb/tb_mini_rv_core.sv
